/* rtl/kyber_enc_pkg.sv */
// shared sizes, modulus, write-port address map and coefficient types
// for the kyber noise-plus-message back end; reached by scoped names
`default_nettype none

package kyber_enc_pkg;

  // polynomial and modulus
  localparam int KYBER_N = 256;
  localparam int KYBER_Q = 3329;
  // decompressed value of a set message bit, round(q/2)
  localparam int Q_HALF = 1665;

  // operand sizes in bytes
  localparam int MSG_BYTES = 32;
  // two cbd nibbles per byte
  localparam int NOISE_BYTES = 128;

  // write port address map
  localparam int IN_ADR_W = 9;
  localparam logic [IN_ADR_W-1:0] MSG_BASE = 9'h000;
  localparam logic [IN_ADR_W-1:0] NOISE_BASE = 9'h080;
  // bit 0 of the written byte starts a run
  localparam logic [IN_ADR_W-1:0] CTRL_ADDR = 9'h100;

  // read port data width, coefficient zero-extended
  localparam int OUT_DAT_W = 16;

  typedef logic [7:0] byte_t;
  // always below KYBER_Q
  typedef logic [11:0] coef_t;
  // also the read port address
  typedef logic [$clog2(KYBER_N)-1:0] coef_idx_t;
  typedef logic [$clog2(MSG_BYTES)-1:0] msg_addr_t;
  typedef logic [$clog2(NOISE_BYTES)-1:0] noise_addr_t;

endpackage

`default_nettype wire

/* rtl/sync_ram.sv */
// single-clock memory, one write port and one registered read port
// element type set per instance, one cycle read latency
`timescale 1ns/10ps
`default_nettype none

module sync_ram #(
  parameter int DEPTH = 32,
  parameter type elem_t = logic [7:0]
) (
  input  wire logic                     clk,
  input  wire logic                     we,
  input  wire logic [$clog2(DEPTH)-1:0] waddr,
  input  wire elem_t                    wdata,
  input  wire logic [$clog2(DEPTH)-1:0] raddr,
  output elem_t                         rdata
);

  elem_t mem [DEPTH];

  // read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

/* rtl/kyber_enc_loader.sv */
// input side: wishbone classic write slave filling the message and noise
// buffers, plus the control register that fires the start pulse
`timescale 1ns/10ps
`default_nettype none

module kyber_enc_loader (
  input  wire logic                                  clk,
  input  wire logic                                  reset,
  // wishbone write port
  input  wire logic                                  in_cyc,
  input  wire logic                                  in_stb,
  input  wire logic                                  in_we,
  input  wire logic [kyber_enc_pkg::IN_ADR_W-1:0]    in_adr,
  input  wire kyber_enc_pkg::byte_t                  in_dat,
  output logic                                       in_ack,
  // run control
  input  wire logic                                  busy,
  output logic                                       start,
  // buffer read side, driven by the unit
  input  wire kyber_enc_pkg::msg_addr_t              msg_raddr,
  output kyber_enc_pkg::byte_t                       msg_rdata,
  input  wire kyber_enc_pkg::noise_addr_t            noise_raddr,
  output kyber_enc_pkg::byte_t                       noise_rdata
);

  logic                               req;
  logic                               accept;
  logic [kyber_enc_pkg::IN_ADR_W-1:0] msg_off;
  logic [kyber_enc_pkg::IN_ADR_W-1:0] noise_off;
  logic                               msg_hit;
  logic                               noise_hit;
  logic                               ctrl_hit;
  logic                               msg_we;
  logic                               noise_we;

  assign req = in_cyc & in_stb;

  // one accept per transfer
  // stb is still high during the ack cycle, so that cycle is skipped
  // busy holds the whole transfer off, operands stay frozen during a run
  assign accept = req & ~busy & ~in_ack;

  // region offsets, wrap below the base keeps them out of range
  assign msg_off   = in_adr - kyber_enc_pkg::MSG_BASE;
  assign noise_off = in_adr - kyber_enc_pkg::NOISE_BASE;

  assign msg_hit   = msg_off < kyber_enc_pkg::IN_ADR_W'(kyber_enc_pkg::MSG_BYTES);
  assign noise_hit = noise_off < kyber_enc_pkg::IN_ADR_W'(kyber_enc_pkg::NOISE_BYTES);
  assign ctrl_hit  = in_adr == kyber_enc_pkg::CTRL_ADDR;

  // unmapped addresses still get acked, nothing is written
  assign msg_we   = accept & in_we & msg_hit;
  assign noise_we = accept & in_we & noise_hit;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      in_ack <= 1'b0;
      start  <= 1'b0;
    end else begin
      in_ack <= accept;
      // start lines up with the ack of the control write
      start  <= accept & in_we & ctrl_hit & in_dat[0];
    end
  end

  // message bytes, bit i of the message is bit i%8 of byte i/8
  sync_ram #(
    .DEPTH  (kyber_enc_pkg::MSG_BYTES),
    .elem_t (kyber_enc_pkg::byte_t)
  ) msg_ram (
    .clk   (clk),
    .we    (msg_we),
    .waddr (kyber_enc_pkg::msg_addr_t'(msg_off)),
    .wdata (in_dat),
    .raddr (msg_raddr),
    .rdata (msg_rdata)
  );

  // hashed noise, low nibble serves the even coefficient
  sync_ram #(
    .DEPTH  (kyber_enc_pkg::NOISE_BYTES),
    .elem_t (kyber_enc_pkg::byte_t)
  ) noise_ram (
    .clk   (clk),
    .we    (noise_we),
    .waddr (kyber_enc_pkg::noise_addr_t'(noise_off)),
    .wdata (in_dat),
    .raddr (noise_raddr),
    .rdata (noise_rdata)
  );

endmodule

`default_nettype wire

/* rtl/kyber_enc_unit.sv */
// coefficient sequencer with the cbd, message decompress and mod-q add
// pipeline issuing one index per cycle into the reader's buffer
`timescale 1ns/10ps
`default_nettype none

module kyber_enc_unit (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic                        start,
  output logic                             busy,
  output logic                             done,
  // operand buffers return data one cycle later
  output kyber_enc_pkg::msg_addr_t         msg_raddr,
  input  wire kyber_enc_pkg::byte_t        msg_rdata,
  output kyber_enc_pkg::noise_addr_t       noise_raddr,
  input  wire kyber_enc_pkg::byte_t        noise_rdata,
  // result buffer write
  output logic                             res_we,
  output kyber_enc_pkg::coef_idx_t         res_waddr,
  output kyber_enc_pkg::coef_t             res_wdata
);

  localparam kyber_enc_pkg::coef_idx_t LAST_IDX =
    kyber_enc_pkg::coef_idx_t'(kyber_enc_pkg::KYBER_N - 1);

  // issue stage
  logic                      issue_valid;
  kyber_enc_pkg::coef_idx_t  issue_idx;
  // sample stage lines up with the buffer read data
  logic                      s1_valid;
  kyber_enc_pkg::coef_idx_t  s1_idx;
  logic [3:0]                nibble;
  logic [1:0]                pos_sum;
  logic [1:0]                neg_sum;
  kyber_enc_pkg::coef_t      cbd_val;
  kyber_enc_pkg::coef_t      msg_val;
  // add stage
  logic                      s2_valid;
  kyber_enc_pkg::coef_idx_t  s2_idx;
  kyber_enc_pkg::coef_t      s2_cbd;
  kyber_enc_pkg::coef_t      s2_msg;
  // one bit wider than coef_t to hold 3328 + 1665
  logic [12:0]               sum;

  // issue counter walks 0 .. n-1 on the cycles after start
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      issue_valid <= 1'b0;
      issue_idx   <= '0;
    end else if (start) begin
      issue_valid <= 1'b1;
      issue_idx   <= '0;
    end else if (issue_valid) begin
      issue_idx <= issue_idx + 1'b1;
      if (issue_idx == LAST_IDX) begin
        issue_valid <= 1'b0;
      end
    end
  end

  // eight message bits and two noise nibbles per byte
  assign msg_raddr   = kyber_enc_pkg::msg_addr_t'(issue_idx >> 3);
  assign noise_raddr = kyber_enc_pkg::noise_addr_t'(issue_idx >> 1);

  // cbd eta 2 is (b0 + b1) - (b2 + b3)
  // negative values fold to q - x
  always_comb begin
    nibble  = s1_idx[0] ? noise_rdata[7:4] : noise_rdata[3:0];
    pos_sum = {1'b0, nibble[0]} + {1'b0, nibble[1]};
    neg_sum = {1'b0, nibble[2]} + {1'b0, nibble[3]};
    if (pos_sum >= neg_sum) begin
      cbd_val = kyber_enc_pkg::coef_t'(pos_sum - neg_sum);
    end else begin
      cbd_val = kyber_enc_pkg::coef_t'(kyber_enc_pkg::KYBER_Q)
              - kyber_enc_pkg::coef_t'(neg_sum - pos_sum);
    end
    // message decompress takes the bits lsb first
    msg_val = msg_rdata[s1_idx[2:0]] ? kyber_enc_pkg::coef_t'(kyber_enc_pkg::Q_HALF) : '0;
  end

  // valid bits follow the index down the pipeline
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_idx <= issue_idx;
    s2_idx <= s1_idx;
    s2_cbd <= cbd_val;
    s2_msg <= msg_val;
  end

  // both inputs below q, so one conditional subtract is enough
  assign sum       = {1'b0, s2_cbd} + {1'b0, s2_msg};
  assign res_wdata = (sum >= 13'(kyber_enc_pkg::KYBER_Q))
                   ? kyber_enc_pkg::coef_t'(sum - 13'(kyber_enc_pkg::KYBER_Q))
                   : kyber_enc_pkg::coef_t'(sum);
  assign res_we    = s2_valid;
  assign res_waddr = s2_idx;

  // busy from the cycle after start until the last write has landed
  // done holds until the next start
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
    end else if (s2_valid && s2_idx == LAST_IDX) begin
      busy <= 1'b0;
      done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/kyber_enc_reader.sv */
// output side: result buffer and wishbone classic read slave, reads are
// held off while a run is in progress
`timescale 1ns/10ps
`default_nettype none

module kyber_enc_reader (
  input  wire logic                               clk,
  input  wire logic                               reset,
  // wishbone read port
  input  wire logic                               out_cyc,
  input  wire logic                               out_stb,
  input  wire kyber_enc_pkg::coef_idx_t           out_adr,
  output logic [kyber_enc_pkg::OUT_DAT_W-1:0]     out_dat,
  output logic                                    out_ack,
  // run status
  input  wire logic                               busy,
  // result writes from the unit
  input  wire logic                               res_we,
  input  wire kyber_enc_pkg::coef_idx_t           res_waddr,
  input  wire kyber_enc_pkg::coef_t               res_wdata
);

  logic                 accept;
  kyber_enc_pkg::coef_t result_rdata;

  // same accept rule as the write port
  // no second ack while stb is still up
  assign accept = out_cyc & out_stb & ~busy & ~out_ack;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_ack <= 1'b0;
    end else begin
      out_ack <= accept;
    end
  end

  // adr is steady through the request
  // the registered read lands on the ack cycle
  sync_ram #(
    .DEPTH  (kyber_enc_pkg::KYBER_N),
    .elem_t (kyber_enc_pkg::coef_t)
  ) result_ram (
    .clk   (clk),
    .we    (res_we),
    .waddr (res_waddr),
    .wdata (res_wdata),
    .raddr (out_adr),
    .rdata (result_rdata)
  );

  // zero-extend onto the bus
  assign out_dat = kyber_enc_pkg::OUT_DAT_W'(result_rdata);

endmodule

`default_nettype wire

/* rtl/kyber_enc_top.sv */
// top level of the noise-plus-message back end
// loader, unit and reader joined, two wishbone slaves brought out
`timescale 1ns/10ps
`default_nettype none

module kyber_enc_top (
  input  wire logic                               clk,
  input  wire logic                               reset,
  // wishbone write port
  input  wire logic                               in_cyc,
  input  wire logic                               in_stb,
  input  wire logic                               in_we,
  input  wire logic [kyber_enc_pkg::IN_ADR_W-1:0] in_adr,
  input  wire kyber_enc_pkg::byte_t               in_dat,
  output logic                                    in_ack,
  // wishbone read port
  input  wire logic                               out_cyc,
  input  wire logic                               out_stb,
  input  wire kyber_enc_pkg::coef_idx_t           out_adr,
  output logic [kyber_enc_pkg::OUT_DAT_W-1:0]     out_dat,
  output logic                                    out_ack,
  // status
  output logic                                    busy,
  output logic                                    done
);

  logic                       start;
  kyber_enc_pkg::msg_addr_t   msg_raddr;
  kyber_enc_pkg::byte_t       msg_rdata;
  kyber_enc_pkg::noise_addr_t noise_raddr;
  kyber_enc_pkg::byte_t       noise_rdata;
  logic                       res_we;
  kyber_enc_pkg::coef_idx_t   res_waddr;
  kyber_enc_pkg::coef_t       res_wdata;

  // operands in, start pulse out
  kyber_enc_loader u_loader (
    .clk         (clk),
    .reset       (reset),
    .in_cyc      (in_cyc),
    .in_stb      (in_stb),
    .in_we       (in_we),
    .in_adr      (in_adr),
    .in_dat      (in_dat),
    .in_ack      (in_ack),
    .busy        (busy),
    .start       (start),
    .msg_raddr   (msg_raddr),
    .msg_rdata   (msg_rdata),
    .noise_raddr (noise_raddr),
    .noise_rdata (noise_rdata)
  );

  // busy gates both slaves
  kyber_enc_unit u_unit (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .busy        (busy),
    .done        (done),
    .msg_raddr   (msg_raddr),
    .msg_rdata   (msg_rdata),
    .noise_raddr (noise_raddr),
    .noise_rdata (noise_rdata),
    .res_we      (res_we),
    .res_waddr   (res_waddr),
    .res_wdata   (res_wdata)
  );

  kyber_enc_reader u_reader (
    .clk       (clk),
    .reset     (reset),
    .out_cyc   (out_cyc),
    .out_stb   (out_stb),
    .out_adr   (out_adr),
    .out_dat   (out_dat),
    .out_ack   (out_ack),
    .busy      (busy),
    .res_we    (res_we),
    .res_waddr (res_waddr),
    .res_wdata (res_wdata)
  );

endmodule

`default_nettype wire

/* tests/kyber_enc_asserts.sv */
// concurrent checks on both wishbone ports and the run status
// attached to kyber_enc_top by the bind at the end
`timescale 1ns/10ps
`default_nettype none

module kyber_enc_asserts (
  input wire logic clk,
  input wire logic reset,
  input wire logic in_cyc,
  input wire logic in_stb,
  input wire logic in_ack,
  input wire logic out_cyc,
  input wire logic out_stb,
  input wire logic out_ack,
  input wire logic busy,
  input wire logic done
);

  // ack is a one-cycle pulse
  assert property (@(posedge clk) disable iff (reset) in_ack |=> !in_ack)
    else $error("in_ack held for more than one cycle");
  assert property (@(posedge clk) disable iff (reset) out_ack |=> !out_ack)
    else $error("out_ack held for more than one cycle");

  // ack only answers a request seen on the cycle before
  assert property (@(posedge clk) disable iff (reset)
    in_ack |-> $past(in_cyc && in_stb))
    else $error("in_ack without a preceding write request");
  assert property (@(posedge clk) disable iff (reset)
    out_ack |-> $past(out_cyc && out_stb))
    else $error("out_ack without a preceding read request");

  // running and finished exclude each other
  assert property (@(posedge clk) disable iff (reset) !(busy && done))
    else $error("busy and done high together");

  // both slaves stall for the whole run
  assert property (@(posedge clk) disable iff (reset) busy |-> (!in_ack && !out_ack))
    else $error("bus ack while busy");

endmodule

bind kyber_enc_top kyber_enc_asserts u_asserts (
  .clk     (clk),
  .reset   (reset),
  .in_cyc  (in_cyc),
  .in_stb  (in_stb),
  .in_ack  (in_ack),
  .out_cyc (out_cyc),
  .out_stb (out_stb),
  .out_ack (out_ack),
  .busy    (busy),
  .done    (done)
);

`default_nettype wire

/* tests/kyber_enc_tb.sv */
// testbench for the kyber noise-plus-message back end
// fill-pattern table, one random case, back-pressure and unmapped writes
`timescale 1ns/10ps
`default_nettype none

module kyber_enc_tb;

  localparam int NUM_ROWS = 5;
  localparam int ACK_TIMEOUT = 1000;
  localparam int DONE_TIMEOUT = 1000;

  logic                                clk = 1'b0;
  logic                                reset;
  logic                                in_cyc;
  logic                                in_stb;
  logic                                in_we;
  logic [kyber_enc_pkg::IN_ADR_W-1:0]  in_adr;
  kyber_enc_pkg::byte_t                in_dat;
  logic                                in_ack;
  logic                                out_cyc;
  logic                                out_stb;
  kyber_enc_pkg::coef_idx_t            out_adr;
  logic [kyber_enc_pkg::OUT_DAT_W-1:0] out_dat;
  logic                                out_ack;
  logic                                busy;
  logic                                done;

  // operands of the current run, expected result per index
  kyber_enc_pkg::byte_t cur_msg [kyber_enc_pkg::MSG_BYTES];
  kyber_enc_pkg::byte_t cur_noise [kyber_enc_pkg::NOISE_BYTES];
  kyber_enc_pkg::coef_t exp_coef [kyber_enc_pkg::KYBER_N];

  // stimulus table, fill bytes and expected even/odd coefficient per message bit
  kyber_enc_pkg::byte_t row_msg [NUM_ROWS];
  kyber_enc_pkg::byte_t row_noise [NUM_ROWS];
  kyber_enc_pkg::coef_t row_exp_even [NUM_ROWS][8];
  kyber_enc_pkg::coef_t row_exp_odd [NUM_ROWS][8];

  integer                              seed;
  logic                                ack_done;
  logic [kyber_enc_pkg::OUT_DAT_W-1:0] rd_data;

  // 4 ns period
  always #2 clk = ~clk;

  kyber_enc_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .in_cyc  (in_cyc),
    .in_stb  (in_stb),
    .in_we   (in_we),
    .in_adr  (in_adr),
    .in_dat  (in_dat),
    .in_ack  (in_ack),
    .out_cyc (out_cyc),
    .out_stb (out_stb),
    .out_adr (out_adr),
    .out_dat (out_dat),
    .out_ack (out_ack),
    .busy    (busy),
    .done    (done)
  );

  // reference rule: cbd eta 2 of the nibble plus q/2 for a set bit, mod q
  function automatic kyber_enc_pkg::coef_t noise_plus_msg(input logic [3:0] nib,
                                                          input logic msg_bit);
    int val;
    val = int'(nib[0]) + int'(nib[1]) - int'(nib[2]) - int'(nib[3]);
    if (msg_bit) begin
      val = val + kyber_enc_pkg::Q_HALF;
    end
    val = ((val % kyber_enc_pkg::KYBER_Q) + kyber_enc_pkg::KYBER_Q) % kyber_enc_pkg::KYBER_Q;
    return kyber_enc_pkg::coef_t'(val);
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_coef(input string name, input kyber_enc_pkg::coef_t got,
                            input kyber_enc_pkg::coef_t expected);
    if (got !== expected) begin
      report_failure($sformatf("CHECK FAILED at time %0t: %s is %0d, expected %0d",
                               $time, name, got, expected));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      report_failure($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
                               $time, name, got, expected));
    end
  endtask

  task automatic check_ack_order(input string name, input logic done_at_ack);
    if (done_at_ack !== 1'b1) begin
      report_failure($sformatf("%s was acknowledged at time %0t before done rose",
                               name, $time));
    end
  endtask

  // one classic write, stb dropped on the cycle after ack
  task automatic wb_write(input logic [kyber_enc_pkg::IN_ADR_W-1:0] adr,
                          input kyber_enc_pkg::byte_t dat, output logic done_at_ack);
    int waited;
    waited = 0;
    @(posedge clk);
    in_cyc <= 1'b1;
    in_stb <= 1'b1;
    in_we  <= 1'b1;
    in_adr <= adr;
    in_dat <= dat;
    @(negedge clk);
    while (!in_ack && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ack) begin
      report_failure($sformatf("write to address 0x%03h was never acknowledged", adr));
    end
    done_at_ack = done;
    @(posedge clk);
    in_cyc <= 1'b0;
    in_stb <= 1'b0;
    in_we  <= 1'b0;
  endtask

  // one classic read, data taken while ack is high
  task automatic wb_read(input kyber_enc_pkg::coef_idx_t adr,
                         output logic [kyber_enc_pkg::OUT_DAT_W-1:0] data,
                         output logic done_at_ack);
    int waited;
    waited = 0;
    @(posedge clk);
    out_cyc <= 1'b1;
    out_stb <= 1'b1;
    out_adr <= adr;
    @(negedge clk);
    while (!out_ack && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!out_ack) begin
      report_failure($sformatf("read of coefficient %0d was never acknowledged", adr));
    end
    data = out_dat;
    done_at_ack = done;
    @(posedge clk);
    out_cyc <= 1'b0;
    out_stb <= 1'b0;
  endtask

  task automatic load_operands();
    for (int j = 0; j < kyber_enc_pkg::MSG_BYTES; j++) begin
      wb_write(kyber_enc_pkg::MSG_BASE + 9'(j), cur_msg[j], ack_done);
    end
    for (int j = 0; j < kyber_enc_pkg::NOISE_BYTES; j++) begin
      wb_write(kyber_enc_pkg::NOISE_BASE + 9'(j), cur_noise[j], ack_done);
    end
  endtask

  // start write, then done must already be cleared
  task automatic start_run();
    wb_write(kyber_enc_pkg::CTRL_ADDR, 8'h01, ack_done);
    @(negedge clk);
    check_flag("busy", busy, 1'b1);
    check_flag("done", done, 1'b0);
  endtask

  task automatic wait_for_done();
    int waited;
    waited = 0;
    while (!done && waited < DONE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      report_failure("done did not rise after a start write");
    end
    check_flag("busy", busy, 1'b0);
  endtask

  task automatic read_and_compare();
    for (int i = 0; i < kyber_enc_pkg::KYBER_N; i++) begin
      wb_read(kyber_enc_pkg::coef_idx_t'(i), rd_data, ack_done);
      check_flag("out_dat upper bits",
                 |rd_data[kyber_enc_pkg::OUT_DAT_W-1:$bits(kyber_enc_pkg::coef_t)], 1'b0);
      check_coef($sformatf("out_dat[%0d]", i), kyber_enc_pkg::coef_t'(rd_data), exp_coef[i]);
    end
  endtask

  // rows cover zero, all ones, wrap past q and mixed nibbles
  task automatic fill_table();
    row_msg[0] = 8'h00;
    row_noise[0] = 8'h00;
    row_msg[1] = 8'hff;
    row_noise[1] = 8'hff;
    row_msg[2] = 8'ha5;
    row_noise[2] = 8'h3c;
    row_msg[3] = 8'h0f;
    row_noise[3] = 8'hf0;
    row_msg[4] = 8'h5a;
    row_noise[4] = 8'hc3;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int b = 0; b < 8; b++) begin
        row_exp_even[r][b] = noise_plus_msg(row_noise[r][3:0], row_msg[r][b]);
        row_exp_odd[r][b]  = noise_plus_msg(row_noise[r][7:4], row_msg[r][b]);
      end
    end
  endtask

  task automatic use_table_row(input int r);
    for (int j = 0; j < kyber_enc_pkg::MSG_BYTES; j++) begin
      cur_msg[j] = row_msg[r];
    end
    for (int j = 0; j < kyber_enc_pkg::NOISE_BYTES; j++) begin
      cur_noise[j] = row_noise[r];
    end
    // every message byte equal, so bit i%8 and nibble i%2 decide
    for (int i = 0; i < kyber_enc_pkg::KYBER_N; i++) begin
      exp_coef[i] = (i % 2 == 1) ? row_exp_odd[r][i % 8] : row_exp_even[r][i % 8];
    end
  endtask

  task automatic randomize_operands();
    for (int j = 0; j < kyber_enc_pkg::MSG_BYTES; j++) begin
      cur_msg[j] = kyber_enc_pkg::byte_t'($random(seed));
    end
    for (int j = 0; j < kyber_enc_pkg::NOISE_BYTES; j++) begin
      cur_noise[j] = kyber_enc_pkg::byte_t'($random(seed));
    end
    for (int i = 0; i < kyber_enc_pkg::KYBER_N; i++) begin
      exp_coef[i] = noise_plus_msg((i % 2 == 1) ? cur_noise[i / 2][7:4] : cur_noise[i / 2][3:0],
                                   cur_msg[i / 8][i % 8]);
    end
  endtask

  initial begin
    seed = 32'hb00a_eef4;
    reset   <= 1'b1;
    in_cyc  <= 1'b0;
    in_stb  <= 1'b0;
    in_we   <= 1'b0;
    in_adr  <= '0;
    in_dat  <= '0;
    out_cyc <= 1'b0;
    out_stb <= 1'b0;
    out_adr <= '0;
    fill_table();
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // idle state after reset
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("in_ack", in_ack, 1'b0);
    check_flag("out_ack", out_ack, 1'b0);
    repeat (10) begin
      @(negedge clk);
      check_flag("done", done, 1'b0);
    end

    // table rows, each run overwrites the last
    for (int r = 0; r < NUM_ROWS; r++) begin
      use_table_row(r);
      load_operands();
      start_run();
      wait_for_done();
      read_and_compare();
    end

    // random operands, with a read issued while busy
    randomize_operands();
    load_operands();
    start_run();
    wb_read('0, rd_data, ack_done);
    check_ack_order("read during busy", ack_done);
    check_coef("out_dat[0]", kyber_enc_pkg::coef_t'(rd_data), exp_coef[0]);
    wait_for_done();
    read_and_compare();

    // unmapped write and a control write without bit 0 before the run
    randomize_operands();
    load_operands();
    wb_write(9'h1c3, 8'h5a, ack_done);
    wb_write(kyber_enc_pkg::CTRL_ADDR, 8'h00, ack_done);
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b1);
    start_run();
    wb_write(9'h1e7, 8'h01, ack_done);
    check_ack_order("write during busy", ack_done);
    wait_for_done();
    read_and_compare();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
rtl/kyber_enc_pkg.sv
rtl/sync_ram.sv
rtl/kyber_enc_loader.sv
rtl/kyber_enc_unit.sv
rtl/kyber_enc_reader.sv
rtl/kyber_enc_top.sv
tests/kyber_enc_asserts.sv
tests/kyber_enc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the kyber back-end testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module kyber_enc_tb -Mdir obj_dir -o kyber_enc_sim -f build.f

status=0
./obj_dir/kyber_enc_sim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG" || [ "$status" -ne 0 ]; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"
